//--- hw/MemTestPkg.sv
/*
 * Memory tester shared definitions
 * Sizes, latency, word types and the address-derived test pattern
 */
package MemTestPkg;

    localparam int ADDR_WIDTH = 4;
    localparam int MEM_DEPTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int MEM_LATENCY = 2;                 // Accept to ready again
    localparam int LATENCY_COUNT_WIDTH = $clog2(MEM_LATENCY + 1);
    localparam int ERR_COUNT_WIDTH = 8;
    localparam int LED_BLINK_BIT = 3;               // Short for simulation

    typedef logic [ADDR_WIDTH-1:0] MemAddr;
    typedef logic [DATA_WIDTH-1:0] MemWord;

    localparam MemWord FAULT_MASK = MemWord'(1);    // Flip bit 0 only

    // Inverted address in the upper half, plain address in the lower half
    function automatic MemWord testPattern(input MemAddr addr);
        logic [DATA_WIDTH/2-1:0] ext;
        ext = (DATA_WIDTH/2)'(addr);
        return {~ext, ext};
    endfunction

endpackage

//--- hw/MemAccessIf.sv
/*
 * Memory access channel
 * Request side (address, data, read/write enables) and the memory's
 * busy, ready and read-data response
 */
`timescale 1ns/1ps

interface MemAccessIf
    import MemTestPkg::*;
();
    MemAddr addr;
    MemWord writeData;
    logic re;
    logic we;
    logic busy;
    logic ready;                // Initialization finished
    MemWord readData;
    logic readDataReady;

    modport requester (
        output addr, writeData, re, we,
        input busy, ready
    );

    modport memory (
        input addr, writeData, re, we,
        output busy, ready, readData, readDataReady
    );

    modport observer (
        input readData, readDataReady, re, addr
    );

endinterface

//--- hw/InternalMemory.sv
/*
 * Single-port on-chip memory
 * Clears every entry after reset before raising ready, then serves one
 * access at a time with a fixed busy latency
 */
`timescale 1ns/1ps

module InternalMemory
    import MemTestPkg::*;
(
    input logic clk,
    input logic rst,
    MemAccessIf.memory mem
);

    MemWord memArray [MEM_DEPTH];
    MemWord readWord;
    MemAddr initAddr;
    logic initDone;
    logic [LATENCY_COUNT_WIDTH-1:0] latCount;
    logic readPending;
    logic accept;

    // Access taken only when idle and initialized
    assign accept = initDone && (latCount == '0) && (mem.re || mem.we);

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            initAddr <= '0;
            initDone <= 1'b0;
            latCount <= '0;
            readPending <= 1'b0;
        end else begin
            if (!initDone) begin
                initAddr <= initAddr + 1'b1;
                if (initAddr == MemAddr'(MEM_DEPTH - 1)) begin
                    initDone <= 1'b1;       // Last entry cleared this cycle
                end
            end
            if (accept) begin
                latCount <= LATENCY_COUNT_WIDTH'(MEM_LATENCY);
                readPending <= mem.re;
            end else if (latCount != '0) begin
                latCount <= latCount - 1'b1;
            end
        end
    end

    // Storage and read word
    always_ff @(posedge clk) begin
        if (!initDone) begin
            memArray[initAddr] <= '0;       // Clearing stands in for calibration
        end else if (accept && mem.we) begin
            memArray[mem.addr] <= mem.writeData;
        end
        if (accept && mem.re) begin
            readWord <= memArray[mem.addr];
        end
    end

    assign mem.ready = initDone;
    assign mem.busy = (latCount != '0);
    assign mem.readData = readWord;
    assign mem.readDataReady = readPending && (latCount == LATENCY_COUNT_WIDTH'(1));

endmodule

//--- hw/AccessSequencer.sv
/*
 * Access sequencer
 * Writes every entry with its test pattern, then reads every entry back,
 * forever. An armed fault corrupts one write at the requested address
 */
`timescale 1ns/1ps

module AccessSequencer
    import MemTestPkg::*;
(
    input logic clk,
    input logic rst,
    input logic faultArm,
    input MemAddr faultAddr,
    output logic faultApplied,
    MemAccessIf.requester req
);

    MemAddr addr;
    MemAddr armedAddr;
    MemAddr pendingAddr;
    logic writePhase;           // High while writing
    logic armed;
    logic pendingArm;
    logic slotFree;
    logic faultHit;

    assign slotFree = req.ready && !req.busy;

    // A request seen this cycle counts as well as a latched one
    assign pendingArm = armed || faultArm;
    assign pendingAddr = faultArm ? faultAddr : armedAddr;
    assign faultHit = req.we && pendingArm && (addr == pendingAddr);

    assign req.we = slotFree && writePhase;
    assign req.re = slotFree && !writePhase;
    assign req.addr = addr;
    assign req.writeData = faultHit ? (testPattern(addr) ^ FAULT_MASK) : testPattern(addr);
    assign faultApplied = faultHit;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr <= '0;
            writePhase <= 1'b1;
            armed <= 1'b0;
            armedAddr <= '0;
        end else begin
            if (slotFree) begin
                if (addr == MemAddr'(MEM_DEPTH - 1)) begin
                    addr <= '0;
                    writePhase <= ~writePhase;  // Switch pass at the last entry
                end else begin
                    addr <= addr + 1'b1;
                end
            end
            if (faultHit) begin
                armed <= 1'b0;      // Used up
            end else if (faultArm) begin
                armed <= 1'b1;
                armedAddr <= faultAddr;
            end
        end
    end

endmodule

//--- hw/ReadDataChecker.sv
/*
 * Read data checker
 * Tracks the address of each returned word, compares it with the test
 * pattern, counts mismatches and marks the end of each read pass
 */
`timescale 1ns/1ps

module ReadDataChecker
    import MemTestPkg::*;
(
    input logic clk,
    input logic rst,
    MemAccessIf.observer mem,
    output logic passDone,
    output logic [ERR_COUNT_WIDTH-1:0] errorCount,
    output MemAddr lastErrorAddr,
    output logic matched,
    output logic errorSeen
);

    MemAddr expAddr;            // Address of the next word to return
    MemWord expWord;
    logic mismatch;
    logic lastEntry;

    assign expWord = testPattern(expAddr);
    assign mismatch = (mem.readData != expWord);
    assign lastEntry = (expAddr == MemAddr'(MEM_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            expAddr <= '0;
            passDone <= 1'b0;
            errorCount <= '0;
            lastErrorAddr <= '0;
            matched <= 1'b0;
            errorSeen <= 1'b0;
        end else begin
            passDone <= mem.readDataReady && lastEntry;
            if (mem.readDataReady) begin
                expAddr <= lastEntry ? '0 : expAddr + 1'b1;
                matched <= !mismatch;
                if (mismatch) begin
                    if (errorCount != '1) begin
                        errorCount <= errorCount + 1'b1;    // Saturates
                    end
                    lastErrorAddr <= expAddr;
                    errorSeen <= 1'b1;
                end
            end else if (mem.re && (mem.addr == '0)) begin
                expAddr <= '0;      // Realign at the start of a read pass
            end
        end
    end

endmodule

//--- hw/StatusLeds.sv
/*
 * Status LEDs
 * Blink on LED 7, memory and checker status on LEDs 6 to 0
 */
`timescale 1ns/1ps

module StatusLeds
    import MemTestPkg::*;
(
    input logic clk,
    input logic rst,
    input logic matched,
    input logic errorSeen,
    input logic ready,
    input logic re,
    input logic we,
    input logic busy,
    input logic readDataReady,
    output logic [7:0] ledOut
);

    logic [LED_BLINK_BIT:0] blinkCount;

    always_ff @(posedge clk) begin
        if (rst) begin
            blinkCount <= '0;
            ledOut <= '0;
        end else begin
            blinkCount <= blinkCount + 1'b1;
            ledOut <= {blinkCount[LED_BLINK_BIT], matched, re, we, busy,
                       readDataReady, ~ready, errorSeen};  // LED 1 shows init
        end
    end

endmodule

//--- hw/MemTestTop.sv
/*
 * Memory tester top level
 * Self-clearing memory, write/read sequencer, read checker and status LEDs
 */
`timescale 1ns/1ps

module MemTestTop
    import MemTestPkg::*;
(
    input logic clk,
    input logic rst,
    input logic faultArm,
    input MemAddr faultAddr,
    output logic passDone,
    output logic faultApplied,
    output logic [ERR_COUNT_WIDTH-1:0] errorCount,
    output MemAddr lastErrorAddr,
    output logic [7:0] ledOut
);

    logic matched;
    logic errorSeen;

    MemAccessIf memIf();

    InternalMemory u_InternalMemory (
        .clk(clk),
        .rst(rst),
        .mem(memIf.memory)
    );

    AccessSequencer u_AccessSequencer (
        .clk(clk),
        .rst(rst),
        .faultArm(faultArm),
        .faultAddr(faultAddr),
        .faultApplied(faultApplied),
        .req(memIf.requester)
    );

    ReadDataChecker u_ReadDataChecker (
        .clk(clk),
        .rst(rst),
        .mem(memIf.observer),
        .passDone(passDone),
        .errorCount(errorCount),
        .lastErrorAddr(lastErrorAddr),
        .matched(matched),
        .errorSeen(errorSeen)
    );

    // Status taken straight from the access channel
    StatusLeds u_StatusLeds (
        .clk(clk),
        .rst(rst),
        .matched(matched),
        .errorSeen(errorSeen),
        .ready(memIf.ready),
        .re(memIf.re),
        .we(memIf.we),
        .busy(memIf.busy),
        .readDataReady(memIf.readDataReady),
        .ledOut(ledOut)
    );

endmodule

//--- verification/ClockGen.sv
/*
 * Testbench clock and reset
 * 4 ns clock, reset held high for the first 4 rising edges
 */
`timescale 1ns/1ps

module ClockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;          // Released just after an edge
    end

endmodule

//--- verification/MemTestMonitor.sv
/*
 * Memory tester monitor
 * Samples the DUT outputs mid-cycle and compares them with the expected
 * values of the current pass, counting every mismatch
 */
`timescale 1ns/1ps

module MemTestMonitor
    import MemTestPkg::*;
(
    input logic clk,
    input logic rst,
    input logic passDone,
    input logic faultApplied,
    input logic [ERR_COUNT_WIDTH-1:0] errorCount,
    input MemAddr lastErrorAddr,
    input logic [7:0] ledOut,
    input logic [ERR_COUNT_WIDTH-1:0] expCount,
    input logic expFault,
    input MemAddr expErrAddr,
    output int errorTotal,
    output int passCount
);

    int cyclesOut;              // Cycles since reset release
    int faultPulses;            // faultApplied pulses seen in this pass
    int blinkHold;              // Samples since LED 7 last changed
    logic blinkPrev;
    logic stickyDue;            // An earlier pass expected an error
    logic ledCheckDue;
    logic cleanPass;

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("Fail %s in pass %0d: expected 0x%0h, got 0x%0h",
                 name, passCount, expected, actual);
        errorTotal++;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            cyclesOut = 0;
            faultPulses = 0;
            blinkHold = 0;
            blinkPrev = 1'b0;
            stickyDue = 1'b0;
            ledCheckDue = 1'b0;
            cleanPass = 1'b0;
            errorTotal = 0;
            passCount = 0;
        end else begin
            cyclesOut++;
            // Error LED dark until the first expected error, then sticky
            if (stickyDue && ledOut[0] !== 1'b1) reportMismatch("ledOut[0]", 1, ledOut[0]);
            if (!stickyDue && expCount == '0 && ledOut[0] !== 1'b0) begin
                reportMismatch("ledOut[0]", 0, ledOut[0]);
            end
            if (ledOut[7] === blinkPrev) begin
                blinkHold++;
            end else begin
                blinkHold = 0;
            end
            blinkPrev = ledOut[7];
            if (blinkHold == (2 << LED_BLINK_BIT)) begin
                $display("Error: ledOut[7] stopped blinking");
                errorTotal++;
            end
            if (cyclesOut == 4 && ledOut[1] !== 1'b1) reportMismatch("ledOut[1]", 1, ledOut[1]);
            if (cyclesOut <= MEM_DEPTH && passDone) begin
                $display("Error: passDone pulsed while the memory was still clearing");
                errorTotal++;
            end
            if (passCount == 0 && !passDone && errorCount !== '0) begin
                reportMismatch("errorCount", 0, errorCount);
            end
            if (ledCheckDue) begin
                ledCheckDue = 1'b0;
                if (cleanPass && ledOut[6] !== 1'b1) reportMismatch("ledOut[6]", 1, ledOut[6]);
            end
            if (passDone) begin
                if (errorCount !== expCount) reportMismatch("errorCount", expCount, errorCount);
                if (faultPulses != int'(expFault)) begin
                    reportMismatch("faultApplied pulses", expFault, faultPulses);
                end
                if (expCount != '0 && lastErrorAddr !== expErrAddr) begin
                    reportMismatch("lastErrorAddr", expErrAddr, lastErrorAddr);
                end
                // Last read still busy, no new request, memory ready
                if (ledOut[5:1] !== 5'b00110) begin
                    reportMismatch("ledOut[5:1]", 5'b00110, ledOut[5:1]);
                end
                cleanPass = !expFault;
                stickyDue = stickyDue || (expCount != '0);
                ledCheckDue = 1'b1;
                passCount++;
                // A fault at entry 0 lands in the pass-end cycle
                faultPulses = faultApplied ? 1 : 0;
            end else if (faultApplied) begin
                faultPulses++;
            end
        end
    end

endmodule

//--- verification/MemTestTb.sv
/*
 * Memory tester testbench
 * Reads one line per read pass from the stim file, arms faults after each
 * pass end and hands the expected values to the monitor
 */
`timescale 1ns/1ps

module MemTestTb
    import MemTestPkg::*;
();

    localparam int NUM_PASSES = 12;
    localparam int PASS_TIMEOUT = 400;      // Cycles, one pass is about 100
    localparam int FAULT_TIMEOUT = 150;
    localparam int RESET_TIMEOUT = 20;
    localparam int DRIVE_DELAY = 1;

    logic clk;
    logic rst;
    logic faultArm;
    MemAddr faultAddr;
    logic passDone;
    logic faultApplied;
    logic [ERR_COUNT_WIDTH-1:0] errorCount;
    MemAddr lastErrorAddr;
    logic [7:0] ledOut;
    logic [ERR_COUNT_WIDTH-1:0] expCount;
    logic expFault;
    MemAddr expErrAddr;
    int valueErrors;
    int passesChecked;
    int timeouts = 0;
    int otherErrors = 0;
    int appliedPulses = 0;
    logic [7:0] stimWords [3*NUM_PASSES];   // Arm, address, count per pass

    ClockGen u_ClockGen (.clk(clk), .rst(rst));

    MemTestTop u_MemTestTop (
        .clk(clk),
        .rst(rst),
        .faultArm(faultArm),
        .faultAddr(faultAddr),
        .passDone(passDone),
        .faultApplied(faultApplied),
        .errorCount(errorCount),
        .lastErrorAddr(lastErrorAddr),
        .ledOut(ledOut)
    );

    MemTestMonitor u_MemTestMonitor (
        .clk(clk),
        .rst(rst),
        .passDone(passDone),
        .faultApplied(faultApplied),
        .errorCount(errorCount),
        .lastErrorAddr(lastErrorAddr),
        .ledOut(ledOut),
        .expCount(expCount),
        .expFault(expFault),
        .expErrAddr(expErrAddr),
        .errorTotal(valueErrors),
        .passCount(passesChecked)
    );

    // Record of fault pulses for the waiting loop
    always @(negedge clk) begin
        if (!rst && faultApplied) appliedPulses++;
    end

    task automatic nextDrivePoint();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        while (rst && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst) begin
            $display("Timeout: reset was never released");
            timeouts++;
        end
        nextDrivePoint();
    endtask

    task automatic waitForFaultApplied(input int startCount, input int passIndex);
        int cycles;
        cycles = 0;
        while (appliedPulses == startCount && cycles < FAULT_TIMEOUT) begin
            nextDrivePoint();
            cycles++;
        end
        if (appliedPulses == startCount) begin
            $display("Timeout: armed fault for pass %0d was never applied", passIndex);
            timeouts++;
        end
    endtask

    task automatic waitForPassDone(input int passIndex);
        int cycles;
        cycles = 0;
        nextDrivePoint();
        while (!passDone && cycles < PASS_TIMEOUT) begin
            nextDrivePoint();
            cycles++;
        end
        if (!passDone) begin
            $display("Timeout: pass %0d never ended with passDone", passIndex);
            timeouts++;
        end
    endtask

    initial begin
        logic arm;
        MemAddr addr;
        int startPulses;
        faultArm = 1'b0;
        faultAddr = '0;
        expCount = '0;
        expFault = 1'b0;
        expErrAddr = '0;
        $readmemh("verification/memtest_stim.txt", stimWords);
        waitForReset();
        for (int i = 0; i < NUM_PASSES; i++) begin
            if ($isunknown({stimWords[3*i], stimWords[3*i+1], stimWords[3*i+2]})) begin
                $display("Stimulus line %0d is missing or unreadable", i);
                otherErrors++;
            end
            arm = stimWords[3*i][0];
            addr = stimWords[3*i+1][ADDR_WIDTH-1:0];
            startPulses = appliedPulses;
            if (arm) begin
                faultAddr = addr;
                faultArm = 1'b1;        // Same cycle as the previous passDone
            end
            nextDrivePoint();
            faultArm = 1'b0;
            expCount = stimWords[3*i+2];
            expFault = arm;
            if (arm) begin
                expErrAddr = addr;
                waitForFaultApplied(startPulses, i);
            end
            waitForPassDone(i);
        end
        repeat (2) nextDrivePoint();    // Room for the last LED check
        if (passesChecked != NUM_PASSES) begin
            $display("Monitor saw %0d pass ends instead of %0d", passesChecked, NUM_PASSES);
            otherErrors++;
        end
        $display("Summary: %0d passes, %0d value errors, %0d timeouts, %0d other errors",
                 passesChecked, valueErrors, timeouts, otherErrors);
        if (valueErrors == 0 && timeouts == 0 && otherErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verification/memtest_stim.txt
// One read pass per line, hex: fault arm bit, fault address, expected errorCount
// after that pass (cumulative). The arm is driven in the previous pass-end cycle
0 0 00
0 0 00
0 0 00
1 5 01
0 0 01
1 0 02
0 0 02
1 F 03
0 0 03
1 A 04
1 3 05
0 0 05

//--- all.f
hw/MemTestPkg.sv
hw/MemAccessIf.sv
hw/InternalMemory.sv
hw/AccessSequencer.sv
hw/ReadDataChecker.sv
hw/StatusLeds.sv
hw/MemTestTop.sv
verification/ClockGen.sv
verification/MemTestMonitor.sv
verification/MemTestTb.sv
